//--- hdl/vga_text_pkg.sv
/*
  text-mode vga controller shared definitions
  raster timing, text grid sizes, command bytes, colours and bus structs
*/
package vga_text_pkg;

  ////////////////////////////////////////
  // raster timing
  ////////////////////////////////////////

  // horizontal, in pixels
  localparam int H_VISIBLE = 64;
  localparam int H_FRONT   = 4;
  localparam int H_SYNC    = 8;
  localparam int H_BACK    = 12;
  localparam int H_TOTAL   = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;

  // vertical, in lines
  localparam int V_VISIBLE = 16;
  localparam int V_FRONT   = 2;
  localparam int V_SYNC    = 2;
  localparam int V_BACK    = 4;
  localparam int V_TOTAL   = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;

  ////////////////////////////////////////
  // text grid and memories
  ////////////////////////////////////////

  localparam int GLYPH_W     = 8;
  localparam int GLYPH_H     = 8;
  localparam int TEXT_COLS   = 8;
  localparam int TEXT_ROWS   = 2;
  localparam int GLYPH_COUNT = 16;
  // one byte per glyph row, one byte per character cell
  localparam int FONT_DEPTH  = GLYPH_COUNT * GLYPH_H;
  localparam int CHAR_DEPTH  = TEXT_COLS * TEXT_ROWS;
  localparam int FONT_AW     = 7;
  localparam int CHAR_AW     = 4;

  // command bytes, anything else is ignored in idle
  localparam logic [7:0] CMD_LOAD_FONT  = 8'h80;
  localparam logic [7:0] CMD_LOAD_CHARS = 8'h82;

  ////////////////////////////////////////
  // buses
  ////////////////////////////////////////

  typedef struct packed {
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
  } rgb_t;

  // yellow on dark purple
  localparam rgb_t FG_COLOR = '{red: 4'hf, green: 4'hf, blue: 4'h0};
  localparam rgb_t BG_COLOR = '{red: 4'h2, green: 4'h0, blue: 4'h8};

  // command byte, valid only while strobe is high
  typedef struct packed {
    logic       strobe;
    logic [7:0] data;
  } cmd_in_t;

  // memory write request, each memory uses only its low address bits
  typedef struct packed {
    logic       en;
    logic [7:0] addr;
    logic [7:0] data;
  } ram_wr_t;

  // raster position and raw flags, syncs active low
  typedef struct packed {
    logic [6:0] hpos;
    logic [4:0] vpos;
    logic       hsync;
    logic       vsync;
    logic       vis;
  } raster_pos_t;

  typedef struct packed {
    logic hsync;
    logic vsync;
    logic de;
    rgb_t color;
  } vga_out_t;

endpackage

//--- hdl/cmd_decoder.sv
/*
  command decoder, turns the load commands of the byte stream
  into registered write requests for the font and character memories
*/
`timescale 1ns/10ps

module cmd_decoder
  import vga_text_pkg::*;
(
  input  logic    clk,
  input  logic    arst_n,
  input  cmd_in_t cmd,
  output ram_wr_t font_wr,
  output ram_wr_t char_wr
);

  typedef enum logic [1:0] {ST_IDLE, ST_FONT, ST_CHARS} state_t;

  state_t     state;
  logic [7:0] byte_cnt;
  logic       font_en;
  logic       char_en;
  logic [7:0] wr_addr;
  logic [7:0] wr_data;
  logic       last_byte;

  // final address of whichever memory is being filled
  always_comb
  begin
    if (state == ST_FONT)
      last_byte = (byte_cnt == 8'(FONT_DEPTH - 1));
    else
      last_byte = (byte_cnt == 8'(CHAR_DEPTH - 1));
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state    <= ST_IDLE;
      byte_cnt <= '0;
      font_en  <= 1'b0;
      char_en  <= 1'b0;
    end
    else
    begin
      // write enables are single-cycle pulses
      font_en <= 1'b0;
      char_en <= 1'b0;
      if (cmd.strobe)
      begin
        case (state)
          ST_IDLE:
          begin
            // every load starts at address 0
            byte_cnt <= '0;
            if (cmd.data == CMD_LOAD_FONT)
              state <= ST_FONT;
            else if (cmd.data == CMD_LOAD_CHARS)
              state <= ST_CHARS;
          end
          ST_FONT, ST_CHARS:
          begin
            font_en  <= (state == ST_FONT);
            char_en  <= (state == ST_CHARS);
            byte_cnt <= byte_cnt + 8'd1;
            // load length is exactly the memory depth
            if (last_byte)
              state <= ST_IDLE;
          end
          default:
            state <= ST_IDLE;
        endcase
      end
    end
  end

  // address and data, shared by both memories since only one loads at a time
  always_ff @(posedge clk)
  begin
    if (cmd.strobe)
    begin
      wr_addr <= byte_cnt;
      wr_data <= cmd.data;
    end
  end

  assign font_wr = '{en: font_en, addr: wr_addr, data: wr_data};
  assign char_wr = '{en: char_en, addr: wr_addr, data: wr_data};

endmodule

//--- hdl/text_ram.sv
/*
  byte ram with one synchronous write port and one registered read port
*/
`timescale 1ns/10ps

module text_ram
  import vga_text_pkg::*;
#(
  parameter int DEPTH = 16
)
(
  input  logic       clk,
  input  ram_wr_t    wr,
  input  logic [7:0] rd_addr,
  output logic [7:0] rd_data
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

  logic [7:0] mem [DEPTH];

  always_ff @(posedge clk)
  begin
    // upper address bits beyond the depth are ignored
    if (wr.en)
      mem[wr.addr[AW-1:0]] <= wr.data;
    // read data follows the address by one cycle
    rd_data <= mem[rd_addr[AW-1:0]];
  end

endmodule

//--- hdl/raster_timing.sv
/*
  raster timing, free-running pixel and line counters
  with raw active-low syncs and the visible flag
*/
`timescale 1ns/10ps

module raster_timing
  import vga_text_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n,
  output raster_pos_t pos
);

  logic [6:0] hcnt;
  logic [4:0] vcnt;
  logic       line_end;

  assign line_end = (hcnt == 7'(H_TOTAL - 1));

  ////////////////////////////////////////
  // counters
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      hcnt <= '0;
      // start in the front porch so the first visible line follows a vsync
      vcnt <= 5'(V_VISIBLE);
    end
    else
    begin
      if (line_end)
      begin
        hcnt <= '0;
        if (vcnt == 5'(V_TOTAL - 1))
          vcnt <= '0;
        else
          vcnt <= vcnt + 5'd1;
      end
      else
        hcnt <= hcnt + 7'd1;
    end
  end

  ////////////////////////////////////////
  // flag decode
  ////////////////////////////////////////

  always_comb
  begin
    pos.hpos  = hcnt;
    pos.vpos  = vcnt;
    // sync windows sit right after the front porches
    pos.hsync = !((hcnt >= 7'(H_VISIBLE + H_FRONT)) &&
                  (hcnt < 7'(H_VISIBLE + H_FRONT + H_SYNC)));
    pos.vsync = !((vcnt >= 5'(V_VISIBLE + V_FRONT)) &&
                  (vcnt < 5'(V_VISIBLE + V_FRONT + V_SYNC)));
    pos.vis   = (hcnt < 7'(H_VISIBLE)) && (vcnt < 5'(V_VISIBLE));
  end

endmodule

//--- hdl/text_renderer.sv
/*
  character renderer, fetches the code and glyph row of each 8-pixel block
  ahead of time, shifts it out and maps bits to colours
*/
`timescale 1ns/10ps

module text_renderer
  import vga_text_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n,
  input  raster_pos_t pos,
  output logic [7:0]  char_addr,
  input  logic [7:0]  char_data,
  output logic [7:0]  font_addr,
  input  logic [7:0]  font_data,
  output vga_out_t    video
);

  // pipeline: char read, font read, shifter, output register
  localparam int DEPTH = 3;

  logic [CHAR_AW-1:0] char_idx;
  logic [FONT_AW-1:0] font_idx;
  logic [4:0]         vpos_d1;
  logic               blk_d1;
  logic               blk_d2;
  logic [7:0]         shifter;
  logic [DEPTH-1:0]   hs_pipe;
  logic [DEPTH-1:0]   vs_pipe;
  logic [DEPTH-1:0]   vis_pipe;
  rgb_t               pix_color;

  ////////////////////////////////////////
  // fetch stages
  ////////////////////////////////////////

  // cell address straight from the raster position, row*cols+col
  assign char_idx  = CHAR_AW'((int'(pos.vpos) / GLYPH_H) * TEXT_COLS +
                              int'(pos.hpos) / GLYPH_W);
  assign char_addr = 8'(char_idx);

  // code returns one cycle later, pick glyph row with the matching line
  assign font_idx  = FONT_AW'(int'(char_data) % GLYPH_COUNT * GLYPH_H +
                              int'(vpos_d1) % GLYPH_H);
  assign font_addr = 8'(font_idx);

  always_ff @(posedge clk)
  begin
    vpos_d1 <= pos.vpos;
  end

  // marks the first pixel of a block as it moves down the fetch stages
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      blk_d1 <= 1'b0;
      blk_d2 <= 1'b0;
    end
    else
    begin
      blk_d1 <= (int'(pos.hpos) % GLYPH_W == 0);
      blk_d2 <= blk_d1;
    end
  end

  ////////////////////////////////////////
  // pixel shifter
  ////////////////////////////////////////

  // glyph byte arrives as the previous block finishes, msb is leftmost
  always_ff @(posedge clk)
  begin
    if (blk_d2)
      shifter <= font_data;
    else
      shifter <= {shifter[6:0], 1'b0};
  end

  // raster flags ride alongside the pixel data
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      hs_pipe  <= '1;
      vs_pipe  <= '1;
      vis_pipe <= '0;
    end
    else
    begin
      hs_pipe  <= {hs_pipe[DEPTH-2:0], pos.hsync};
      vs_pipe  <= {vs_pipe[DEPTH-2:0], pos.vsync};
      vis_pipe <= {vis_pipe[DEPTH-2:0], pos.vis};
    end
  end

  // black outside the visible window
  always_comb
  begin
    if (!vis_pipe[DEPTH-1])
      pix_color = '0;
    else if (shifter[7])
      pix_color = FG_COLOR;
    else
      pix_color = BG_COLOR;
  end

  ////////////////////////////////////////
  // output register
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
      video <= '{hsync: 1'b1, vsync: 1'b1, de: 1'b0, color: '0};
    else
      video <= '{hsync: hs_pipe[DEPTH-1], vsync: vs_pipe[DEPTH-1],
                 de: vis_pipe[DEPTH-1], color: pix_color};
  end

endmodule

//--- hdl/vga_text_top.sv
/*
  text-mode vga controller top, command decoder feeding two text rams
  read by the raster timing and character renderer
*/
`timescale 1ns/10ps

module vga_text_top
  import vga_text_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n,
  input  cmd_in_t  cmd,
  output vga_out_t video
);

  ram_wr_t     font_wr;
  ram_wr_t     char_wr;
  logic [7:0]  font_addr;
  logic [7:0]  font_data;
  logic [7:0]  char_addr;
  logic [7:0]  char_data;
  raster_pos_t pos;

  // producer side
  cmd_decoder u_cmd_decoder (
    .clk     (clk),
    .arst_n  (arst_n),
    .cmd     (cmd),
    .font_wr (font_wr),
    .char_wr (char_wr)
  );

  // glyph rows
  text_ram #(.DEPTH(FONT_DEPTH)) u_font_ram (
    .clk     (clk),
    .wr      (font_wr),
    .rd_addr (font_addr),
    .rd_data (font_data)
  );

  // character codes
  text_ram #(.DEPTH(CHAR_DEPTH)) u_char_ram (
    .clk     (clk),
    .wr      (char_wr),
    .rd_addr (char_addr),
    .rd_data (char_data)
  );

  raster_timing u_raster_timing (
    .clk    (clk),
    .arst_n (arst_n),
    .pos    (pos)
  );

  text_renderer u_text_renderer (
    .clk       (clk),
    .arst_n    (arst_n),
    .pos       (pos),
    .char_addr (char_addr),
    .char_data (char_data),
    .font_addr (font_addr),
    .font_data (font_data),
    .video     (video)
  );

endmodule

//--- bench/tb_clock.sv
/*
  testbench clock and reset, 8 ns period, reset low for 16 cycles
*/
`timescale 1ns/10ps

module tb_clock
(
  output logic clk,
  output logic arst_n
);

  localparam int RESET_CYCLES = 16;

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // release just after an edge so the first active edge is clean
  initial
  begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1 arst_n = 1'b1;
  end

endmodule

//--- bench/tb_checker.sv
/*
  video checker, tracks frame structure of the output stream
  and compares visible pixels with the expected line masks
*/
`timescale 1ns/10ps

module tb_checker
  import vga_text_pkg::*;
(
  input  logic        clk,
  input  logic        arst_n,
  input  vga_out_t    video,
  input  logic        check_req,
  input  logic [63:0] line_mask [16],
  output int          frame_count,
  output int          frames_checked,
  output int          value_errors,
  output int          struct_errors
);

  localparam int LINES_PER_FRAME = 24;
  localparam int DE_LINES        = 16;
  localparam int DE_RUN          = 64;
  // yellow foreground, purple background
  localparam logic [11:0] YELLOW = 12'hff0;
  localparam logic [11:0] PURPLE = 12'h208;

  int          frames       = 0;
  int          checked      = 0;
  int          val_errs     = 0;
  int          str_errs     = 0;
  logic        prev_hsync   = 1'b1;
  logic        prev_vsync   = 1'b1;
  logic        prev_de      = 1'b0;
  logic        in_frame     = 1'b0;
  logic        frame_check  = 1'b0;
  int          hsync_pulses = 0;
  int          de_runs      = 0;
  int          run_len      = 0;
  logic [3:0]  row_idx;
  logic [5:0]  bit_idx;
  logic [11:0] got_color;
  logic [11:0] exp_color;

  assign frame_count    = frames;
  assign frames_checked = checked;
  assign value_errors   = val_errs;
  assign struct_errors  = str_errs;

  ////////////////////////////////////////
  // sampled mid-cycle, away from the edge
  ////////////////////////////////////////

  always @(negedge clk)
  begin
    got_color = video.color;
    if (!arst_n)
    begin
      // idle levels through reset
      if (video.hsync !== 1'b1)
      begin
        $display("FAIL video.hsync in reset got %h expected 1", video.hsync);
        val_errs++;
      end
      if (video.vsync !== 1'b1)
      begin
        $display("FAIL video.vsync in reset got %h expected 1", video.vsync);
        val_errs++;
      end
      if (video.de !== 1'b0)
      begin
        $display("FAIL video.de in reset got %h expected 0", video.de);
        val_errs++;
      end
      in_frame    = 1'b0;
      frame_check = 1'b0;
      run_len     = 0;
    end
    else
    begin
      // each vsync falling edge closes one frame and opens the next
      if (prev_vsync && !video.vsync)
      begin
        if (in_frame)
        begin
          if (hsync_pulses != LINES_PER_FRAME)
          begin
            $display("frame %0d had %0d hsync pulses instead of %0d",
                     frames, hsync_pulses, LINES_PER_FRAME);
            str_errs++;
          end
          if (de_runs != DE_LINES)
          begin
            $display("frame %0d had %0d de runs instead of %0d", frames, de_runs, DE_LINES);
            str_errs++;
          end
          if (frame_check)
            checked++;
        end
        frames++;
        frame_check  = check_req;
        in_frame     = 1'b1;
        hsync_pulses = 0;
        de_runs      = 0;
      end
      if (prev_hsync && !video.hsync)
        hsync_pulses++;
      // nothing visible before the first vsync
      if (!in_frame && video.de !== 1'b0)
      begin
        $display("de went high before the first vsync");
        str_errs++;
      end
      if (video.de === 1'b1)
      begin
        // x is the position in the run, y the run count in this frame
        if (frame_check && de_runs < DE_LINES && run_len < DE_RUN)
        begin
          row_idx   = 4'(de_runs);
          bit_idx   = 6'(DE_RUN - 1 - run_len);
          exp_color = line_mask[row_idx][bit_idx] ? YELLOW : PURPLE;
          if (got_color !== exp_color)
          begin
            $display("FAIL video.color x=%0d y=%0d got %h expected %h",
                     run_len, de_runs, got_color, exp_color);
            val_errs++;
          end
        end
        run_len++;
      end
      else if (prev_de)
      begin
        if (run_len != DE_RUN)
        begin
          $display("de run of %0d cycles instead of %0d", run_len, DE_RUN);
          str_errs++;
        end
        de_runs++;
        run_len = 0;
      end
    end
    // blanking is always black
    if (video.de !== 1'b1 && got_color !== 12'h000)
    begin
      $display("FAIL video.color with de low got %h expected 000", got_color);
      val_errs++;
    end
    prev_hsync = video.hsync;
    prev_vsync = video.vsync;
    prev_de    = video.de;
  end

endmodule

//--- bench/tb_top.sv
/*
  testbench top for the text-mode vga controller
  loads font and text from the golden file and hands whole frames to the checker
*/
`timescale 1ns/10ps

module tb_top
  import vga_text_pkg::*;
();

  // word offsets in the golden file
  localparam int FONT_BASE    = 0;
  localparam int CHARS_A_BASE = 128;
  localparam int CHARS_B_BASE = 144;
  localparam int MASK_A_BASE  = 160;
  localparam int MASK_B_BASE  = 176;
  localparam int GOLDEN_WORDS = 192;
  localparam int FONT_BYTES   = 128;
  localparam int CHAR_BYTES   = 16;
  localparam int MASK_LINES   = 16;
  localparam int CHECKED_FRAMES = 2;
  // three groups of unknown bytes, one font load and two character loads
  localparam int TOTAL_BYTES  = 9 + (FONT_BYTES + 1) + 2 * (CHAR_BYTES + 1);
  localparam int FRAME_CYCLES = 88 * 24;
  // reset, every byte at the longest gap, four frames, then some slack
  localparam int TIMEOUT_CYCLES = 16 + 4 * TOTAL_BYTES + 4 * FRAME_CYCLES + 1000;

  logic        clk;
  logic        arst_n;
  cmd_in_t     cmd;
  vga_out_t    video;
  logic        check_req;
  logic [63:0] line_mask [MASK_LINES];
  logic [63:0] golden [GOLDEN_WORDS];
  logic [31:0] lcg_state = 32'd54;
  int          cycle_count = 0;
  int          frame_count;
  int          frames_checked;
  int          value_errors;
  int          struct_errors;

  tb_clock u_clock (
    .clk    (clk),
    .arst_n (arst_n)
  );

  vga_text_top UUT (
    .clk    (clk),
    .arst_n (arst_n),
    .cmd    (cmd),
    .video  (video)
  );

  tb_checker u_checker (
    .clk            (clk),
    .arst_n         (arst_n),
    .video          (video),
    .check_req      (check_req),
    .line_mask      (line_mask),
    .frame_count    (frame_count),
    .frames_checked (frames_checked),
    .value_errors   (value_errors),
    .struct_errors  (struct_errors)
  );

  ////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  task automatic idle_cycles(input int count);
    cmd = '0;
    repeat (count)
    begin
      @(posedge clk);
      #1;
    end
  endtask

  // one strobe, then 0 to 3 idle cycles
  task automatic send_byte(input logic [7:0] value);
    int gap;
    gap = int'(lcg_next() >> 16) % 4;
    cmd.strobe = 1'b1;
    cmd.data   = value;
    @(posedge clk);
    #1;
    if (gap > 0)
      idle_cycles(gap);
  endtask

  // bytes the decoder must ignore while idle
  task automatic send_unknown();
    send_byte(8'h00);
    send_byte(8'h81);
    send_byte(8'h7f);
  endtask

  task automatic load_font();
    send_byte(CMD_LOAD_FONT);
    for (int i = 0; i < FONT_BYTES; i++)
      send_byte(golden[FONT_BASE + i][7:0]);
    idle_cycles(2);
  endtask

  task automatic load_chars(input int base);
    send_byte(CMD_LOAD_CHARS);
    for (int i = 0; i < CHAR_BYTES; i++)
      send_byte(golden[base + i][7:0]);
    idle_cycles(2);
  endtask

  // arm the checker for the next full frame and wait until it is done
  task automatic check_frame(input int mask_base);
    int start_count;
    int done_target;
    for (int i = 0; i < MASK_LINES; i++)
      line_mask[i] = golden[mask_base + i];
    idle_cycles(4);
    start_count = frame_count;
    done_target = frames_checked + 1;
    check_req   = 1'b1;
    while (frame_count == start_count)
    begin
      @(posedge clk);
      #1;
    end
    check_req = 1'b0;
    while (frames_checked < done_target)
    begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic finish_run(input logic aborted);
    $display("value errors %0d, structure errors %0d, frames checked %0d of %0d",
             value_errors, struct_errors, frames_checked, CHECKED_FRAMES);
    if (!aborted && value_errors == 0 && struct_errors == 0 &&
        frames_checked == CHECKED_FRAMES)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  endtask

  ////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////

  initial
  begin
    cmd       = '0;
    check_req = 1'b0;
    for (int i = 0; i < MASK_LINES; i++)
      line_mask[i] = '0;
    $readmemh("bench/golden_frames.txt", golden);
    while (arst_n !== 1'b1)
      @(posedge clk);
    @(posedge clk);
    #1;
    send_unknown();
    load_font();
    send_unknown();
    load_chars(CHARS_A_BASE);
    // idle bytes after the last load must leave both memories intact
    send_unknown();
    check_frame(MASK_A_BASE);
    // only the characters change and the font must stay
    load_chars(CHARS_B_BASE);
    check_frame(MASK_B_BASE);
    finish_run(1'b0);
  end

  // run limit
  initial
  begin
    while (cycle_count < TIMEOUT_CYCLES)
    begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
    finish_run(1'b1);
  end

endmodule

//--- bench/golden_frames.txt
// hex words in order: font 128 bytes (glyph 0 row 0 first), chars A 16, chars B 16,
// line masks A 16 and line masks B 16, 64 bits each with bit 63 at x=0
// font, two glyphs per line
00 00 00 00 00 00 00 00 FF 81 81 81 81 81 81 FF
18 3C 66 C3 C3 66 3C 18 80 40 20 10 08 04 02 01
01 02 04 08 10 20 40 80 AA 55 AA 55 AA 55 AA 55
F0 F0 F0 F0 0F 0F 0F 0F 3C 42 81 81 81 81 42 3C
10 38 7C FE 10 10 10 10 7E 60 60 7C 06 06 66 3C
18 24 42 7E 42 42 42 00 7C 42 42 7C 42 42 7C 00
3C 42 40 40 40 42 3C 00 78 44 42 42 42 44 78 00
7E 40 40 7C 40 40 7E 00 0F 1E 3C 78 F0 E1 C3 87
// chars A, row 0 then row 1
0A 0B 0C 0D 0E 00 01 02 13 24 35 46 57 68 79 8F
// chars B
01 02 03 04 05 06 07 08 F9 E0 DF CE BD AC 9B 8A
// masks A, lines 0 to 15
187C3C787E00FF18 244242444000813C
4242404240008166 7E7C40427C0081C3
42424042400081C3 4242424440008166
427C3C787E00813C 000000000000FF18
8001AAF03C107E0F 400255F04238601E
2004AAF0817C603C 100855F081FE7C78
0810AA0F811006F0 0420550F811006E1
0240AA0F421066C3 0180550F3C103C87
// masks B, lines 0 to 15
FF188001AAF03C10 813C400255F04238
81662004AAF0817C 81C3100855F081FE
81C30810AA0F8110 81660420550F8110
813C0240AA0F4210 FF180180550F3C10
7E000F7E783C7C18 60001E4044424224
60003C4042404242 7C00787C42407C7E
0600F04042404242 0600E14044424242
6600C37E783C7C42 3C00870000000000

//--- vga_text.f
hdl/vga_text_pkg.sv
hdl/cmd_decoder.sv
hdl/text_ram.sv
hdl/raster_timing.sv
hdl/text_renderer.sv
hdl/vga_text_top.sv
bench/tb_clock.sv
bench/tb_checker.sv
bench/tb_top.sv

//--- Makefile
# verilator build and run of the text-mode vga controller testbench

TOP := tb_top

.PHONY: help test clean

help:
	@echo "make test   build with verilator, run the testbench, check for a pass"
	@echo "make clean  remove the build output"
	@echo "make help   list these targets"

test:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f vga_text.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "^No errors$$"

clean:
	rm -rf obj_dir
